/* project.f */
+incdir+include
design/cpuPkg.sv
design/stageReg.sv
design/instrDecoder.sv
design/regFile.sv
design/executeStage.sv
design/cpuPipeline.sv
bench/cpuPipeline_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
TOP       := cpuPipeline_tb
FILELIST  := project.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)

/* bench/cpuPipeline_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module cpuPipeline_tb;

    import cpuPkg::*;

    localparam int READY_TIMEOUT = 100;     // Cycles allowed for instrReady
    localparam int DRAIN_TIMEOUT = 300;     // Cycles allowed for the last writebacks
    localparam regIdxT XZR = regIdxT'(`CPU_ZERO_REG);

    logic        clk;
    logic        rst;
    instrT       instr;
    logic        instrValid;
    logic        instrReady;
    regIdxT      wbReg;
    dataT        wbData;
    logic        wbValid;
    logic        wbReady;
    logic [31:0] lfsrState;                 // Back-pressure source

    instrT  instrQ[$];                      // Stimulus table with one row per test
    logic   expWbQ[$];
    regIdxT expRegQ[$];
    dataT   expDataQ[$];
    string  nameQ[$];
    int     expectedCount = 0;
    int     wbSeen = 0;
    int     monIdx = 0;                     // Next row the monitor expects
    int     errorCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    logic   timedOut = 1'b0;

    cpuPipeline u_cpuPipeline (
        .clk(clk), .rst(rst),
        .instr(instr), .instrValid(instrValid), .instrReady(instrReady),
        .wbReg(wbReg), .wbData(wbData), .wbValid(wbValid), .wbReady(wbReady)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;              // 10 ns period
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];  // Taps 32 22 2 1
        return {state[30:0], feedback};
    endfunction

    function automatic instrT encodeR(input logic [10:0] op, input regIdxT rd,
                                      input regIdxT rn, input regIdxT rm);
        return {op, rm, 6'd0, rn, rd};
    endfunction

    function automatic instrT encodeI(input logic [9:0] op, input regIdxT rd,
                                      input regIdxT rn, input logic [11:0] imm12);
        return {op, imm12, rn, rd};
    endfunction

    task automatic addEntry(input string name, input instrT word, input logic expWb,
                            input regIdxT expReg, input dataT expData);
        instrQ.push_back(word);
        expWbQ.push_back(expWb);
        expRegQ.push_back(expReg);
        expDataQ.push_back(expData);
        nameQ.push_back(name);
        if (expWb) expectedCount++;
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkReg(input regIdxT got, input regIdxT exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s wrote x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic checkData(input dataT got, input dataT exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s gave 0x%h, expected 0x%h", $time, what, got, exp);
        end
    endtask

    task automatic reportTest(input int num, input string name, input logic ok);
        if (ok) passCount++;
        else failCount++;
        $display("Test %0d %s: %s", num, name, ok ? "pass" : "fail");
    endtask

    // Rows without a writeback finish once a later row or the end is reached
    task automatic skipNoWriteback();
        while (monIdx < nameQ.size() && !expWbQ[monIdx]) begin
            reportTest(monIdx + 1, nameQ[monIdx], 1'b1);
            monIdx++;
        end
    endtask

    // ==============================
    // Program and expected results
    // ==============================
    task automatic buildTable();
        addEntry("ADDI x1 seed", encodeI(`CPU_OP_ADDI, 5'd1, XZR, 12'd5), 1'b1, 5'd1, 64'd5);
        addEntry("ADDI x2 seed", encodeI(`CPU_OP_ADDI, 5'd2, XZR, 12'd3), 1'b1, 5'd2, 64'd3);
        addEntry("ADD x3", encodeR(`CPU_OP_ADD, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 64'd8);
        addEntry("SUB x4 wraps", encodeR(`CPU_OP_SUB, 5'd4, 5'd2, 5'd1), 1'b1, 5'd4,
                 64'hFFFF_FFFF_FFFF_FFFE);  // 3 - 5
        addEntry("AND x5", encodeR(`CPU_OP_AND, 5'd5, 5'd3, 5'd4), 1'b1, 5'd5, 64'd8);
        addEntry("ORR x6", encodeR(`CPU_OP_ORR, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, 64'd7);
        addEntry("ADDI x7 dist 1", encodeI(`CPU_OP_ADDI, 5'd7, 5'd6, 12'd100), 1'b1, 5'd7,
                 64'd107);
        addEntry("ADD x8 dist 1", encodeR(`CPU_OP_ADD, 5'd8, 5'd7, 5'd7), 1'b1, 5'd8, 64'd214);
        addEntry("SUB x9 dist 1 and 2", encodeR(`CPU_OP_SUB, 5'd9, 5'd8, 5'd7), 1'b1, 5'd9,
                 64'd107);
        addEntry("ADD x10 dist 3 and 1", encodeR(`CPU_OP_ADD, 5'd10, 5'd7, 5'd9), 1'b1, 5'd10,
                 64'd214);
        addEntry("unknown opcode", encodeR(11'h7FF, 5'd20, 5'd1, 5'd2), 1'b0, 5'd0, 64'd0);
        addEntry("ADD to x31", encodeR(`CPU_OP_ADD, XZR, 5'd3, 5'd3), 1'b0, 5'd0, 64'd0);
        addEntry("ORR x12 from x31", encodeR(`CPU_OP_ORR, 5'd12, XZR, 5'd2), 1'b1, 5'd12,
                 64'd3);
        addEntry("ADD x11 from x20", encodeR(`CPU_OP_ADD, 5'd11, 5'd20, 5'd1), 1'b1, 5'd11,
                 64'd5);
        addEntry("SUBI x13 wraps", encodeI(`CPU_OP_SUBI, 5'd13, XZR, 12'd1), 1'b1, 5'd13,
                 64'hFFFF_FFFF_FFFF_FFFF);
        addEntry("ADDI x14 zero ext", encodeI(`CPU_OP_ADDI, 5'd14, 5'd13, 12'hFFF), 1'b1,
                 5'd14, 64'hFFE);           // -1 + 4095
        addEntry("ADDI to x31", encodeI(`CPU_OP_ADDI, XZR, 5'd1, 12'd7), 1'b0, 5'd0, 64'd0);
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin : stimulus
        int   waitCycles;
        logic accepted;
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        buildTable();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);                     // Idle state before any instruction
        checkFlag(wbValid, 1'b0, "wbValid after reset");
        checkFlag(instrReady, 1'b1, "instrReady after reset");
        reportTest(0, "reset state", errorCount == 0);
        for (int i = 0; i < instrQ.size() && !timedOut; i++) begin
            @(negedge clk);
            instr      = instrQ[i];
            instrValid = 1'b1;
            waitCycles = 0;
            accepted   = 1'b0;
            while (!accepted && waitCycles < READY_TIMEOUT) begin
                @(posedge clk);
                accepted = instrReady;      // Transfer on this edge
                waitCycles++;
            end
            if (!accepted) begin
                $display("Timeout: instrReady stayed low while row %0d was offered", i + 1);
                timedOut = 1'b1;
            end
        end
        @(negedge clk);
        instrValid = 1'b0;
        instr      = '0;
        waitCycles = 0;
        while (!timedOut && wbSeen < expectedCount && waitCycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!timedOut && wbSeen < expectedCount) begin
            $display("Timeout: only %0d of %0d writebacks arrived", wbSeen, expectedCount);
            timedOut = 1'b1;
        end
        repeat (10) @(negedge clk);         // Quiet period for stray writebacks
        checkFlag(wbValid, 1'b0, "wbValid after drain");
        skipNoWriteback();
        $display("Tests: %0d passed, %0d failed, %0d check errors", passCount, failCount,
                 errorCount);
        if (!timedOut && failCount == 0 && errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Random wbReady from one LFSR bit per cycle
    initial begin
        wbReady   = 1'b0;
        lfsrState = 32'h41e3;
        forever begin
            @(negedge clk);
            lfsrState = lfsrStep(lfsrState);
            wbReady   = lfsrState[31];
        end
    end

    // ==============================
    // Writeback monitor
    // ==============================
    always @(posedge clk) begin : monitor
        int errBefore;
        if (!rst && wbValid && wbReady) begin
            skipNoWriteback();
            if (monIdx >= nameQ.size()) begin
                errorCount++;
                $display("Fail at %0t: writeback to x%0d with nothing left to expect",
                         $time, wbReg);
            end else begin
                errBefore = errorCount;
                checkReg(wbReg, expRegQ[monIdx], nameQ[monIdx]);
                checkData(wbData, expDataQ[monIdx], nameQ[monIdx]);
                reportTest(monIdx + 1, nameQ[monIdx], errBefore == errorCount);
                monIdx++;
                wbSeen++;
            end
        end
    end

endmodule

`default_nettype wire

/* design/cpuPipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuPipeline (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::instrT  instr,
    input  logic           instrValid,
    output logic           instrReady,
    output cpuPkg::regIdxT wbReg,
    output cpuPkg::dataT   wbData,
    output logic           wbValid,
    input  logic           wbReady
);

    import cpuPkg::*;

    logic   advance;                        // Whole pipe moves
    logic   wbWrite;                        // Writeback handshake
    logic   ifIdValid;
    instrT  ifIdInstr;
    regIdxT rnIdx;
    regIdxT rmIdx;
    regIdxT rdIdx;
    dataT   imm;
    logic   useImm;
    aluOpT  aluOp;
    logic   regWrite;
    dataT   readDataA;
    dataT   readDataB;
    idExT   idExIn;
    idExT   idExOut;
    logic   idExValid;
    dataT   exResult;
    exWbT   exWbIn;
    exWbT   exWbOut;

    // ==============================
    // Stall control
    // ==============================
    assign advance    = !wbValid || wbReady;  // Only WB back-pressure stalls
    assign instrReady = advance;
    assign wbWrite    = wbValid && wbReady;

    stageReg #(.payloadT(instrT)) ifIdReg (
        .clk(clk), .rst(rst), .enable(advance),
        .inValid(instrValid), .inData(instr),
        .outValid(ifIdValid), .outData(ifIdInstr)
    );

    // ==============================
    // Decode and register read
    // ==============================
    instrDecoder u_instrDecoder (
        .instr(ifIdInstr), .instrValid(ifIdValid),
        .rnIdx(rnIdx), .rmIdx(rmIdx), .rdIdx(rdIdx), .imm(imm),
        .useImm(useImm), .aluOp(aluOp), .regWrite(regWrite)
    );

    regFile u_regFile (
        .clk(clk), .rst(rst),
        .readIdxA(rnIdx), .readIdxB(rmIdx),
        .readDataA(readDataA), .readDataB(readDataB),
        .writeEn(wbWrite), .writeIdx(wbReg), .writeData(wbData)
    );

    assign idExIn = '{opA: readDataA, opB: readDataB, rnIdx: rnIdx, rmIdx: rmIdx,
                      rdIdx: rdIdx, imm: imm, useImm: useImm, aluOp: aluOp,
                      regWrite: regWrite};

    // Non-writing instructions enter as bubbles
    stageReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rst(rst), .enable(advance),
        .inValid(regWrite), .inData(idExIn),
        .outValid(idExValid), .outData(idExOut)
    );

    // ==============================
    // Execute and writeback
    // ==============================
    executeStage u_executeStage (
        .idEx(idExOut), .wbValid(wbValid), .wbReg(wbReg),
        .wbData(wbData), .result(exResult)
    );

    assign exWbIn = '{rdIdx: idExOut.rdIdx, result: exResult};

    stageReg #(.payloadT(exWbT)) exWbReg (
        .clk(clk), .rst(rst), .enable(advance),
        .inValid(idExValid && idExOut.regWrite), .inData(exWbIn),
        .outValid(wbValid), .outData(exWbOut)
    );

    assign wbReg  = exWbOut.rdIdx;          // Outside writeback port
    assign wbData = exWbOut.result;

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  cpuPkg::idExT   idEx,
    input  logic           wbValid,         // EX/WB item present
    input  cpuPkg::regIdxT wbReg,
    input  cpuPkg::dataT   wbData,
    output cpuPkg::dataT   result
);

    import cpuPkg::*;

    logic fwdA;
    logic fwdB;
    dataT opA;                              // A after forwarding
    dataT regB;                             // Rm after forwarding
    dataT opB;                              // Final B input

    // ==============================
    // Forwarding from EX/WB
    // ==============================
    // x31 never shows up as wbReg, so no extra guard for it
    assign fwdA = wbValid && (wbReg == idEx.rnIdx);
    assign fwdB = wbValid && (wbReg == idEx.rmIdx);

    assign opA  = fwdA ? wbData : idEx.opA;
    assign regB = fwdB ? wbData : idEx.opB;

    // ALU source select
    assign opB = idEx.useImm ? idEx.imm : regB;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (idEx.aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;    // Two's complement wrap
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::regIdxT readIdxA,
    input  cpuPkg::regIdxT readIdxB,
    output cpuPkg::dataT   readDataA,
    output cpuPkg::dataT   readDataB,
    input  logic           writeEn,
    input  cpuPkg::regIdxT writeIdx,
    input  cpuPkg::dataT   writeData
);

    import cpuPkg::*;

    dataT regs [0:`CPU_NUM_REGS-1];         // x31 entry stays zero

    // One read port, with zero register and write-through
    function automatic dataT readPort(input regIdxT idx, input dataT stored,
                                      input logic wEn, input regIdxT wIdx,
                                      input dataT wData);
        dataT value;
        if (idx == regIdxT'(`CPU_ZERO_REG)) begin
            value = '0;                     // x31 always reads zero
        end else if (wEn && (wIdx == idx)) begin
            value = wData;                  // Same-cycle write wins
        end else begin
            value = stored;
        end
        return value;
    endfunction

    assign readDataA = readPort(readIdxA, regs[readIdxA], writeEn, writeIdx, writeData);
    assign readDataB = readPort(readIdxB, regs[readIdxB], writeEn, writeIdx, writeData);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;              // All registers start at zero
            end
        end else if (writeEn && (writeIdx != regIdxT'(`CPU_ZERO_REG))) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* design/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module instrDecoder (
    input  cpuPkg::instrT  instr,
    input  logic           instrValid,
    output cpuPkg::regIdxT rnIdx,
    output cpuPkg::regIdxT rmIdx,
    output cpuPkg::regIdxT rdIdx,
    output cpuPkg::dataT   imm,
    output logic           useImm,
    output cpuPkg::aluOpT  aluOp,
    output logic           regWrite
);

    import cpuPkg::*;

    logic [10:0] opcode;                    // R-type opcode field
    logic [9:0]  opcodeImm;                 // I-type opcode field
    logic [11:0] imm12;
    logic        knownOp;

    // ==============================
    // Field extraction
    // ==============================
    assign rdIdx     = instr[4:0];
    assign rnIdx     = instr[9:5];
    assign opcode    = instr[31:21];
    assign opcodeImm = instr[31:22];
    assign imm12     = instr[21:10];

    assign imm = {{(`CPU_DATA_W-12){1'b0}}, imm12};  // Zero extend

    // ==============================
    // Control unit
    // ==============================
    always_comb begin
        knownOp = 1'b1;
        useImm  = 1'b0;
        aluOp   = aluAdd;
        case (opcode)
            `CPU_OP_ADD: aluOp = aluAdd;
            `CPU_OP_SUB: aluOp = aluSub;
            `CPU_OP_AND: aluOp = aluAnd;
            `CPU_OP_ORR: aluOp = aluOr;
            default: begin
                useImm = 1'b1;              // Try the 10-bit I-type codes
                case (opcodeImm)
                    `CPU_OP_ADDI: aluOp = aluAdd;
                    `CPU_OP_SUBI: aluOp = aluSub;
                    default: begin
                        knownOp = 1'b0;     // Unknown, becomes a bubble
                        useImm  = 1'b0;
                    end
                endcase
            end
        endcase
    end

    // Second read port, x31 for I-type so B reads zero
    assign rmIdx = useImm ? regIdxT'(`CPU_ZERO_REG) : instr[20:16];

    assign regWrite = instrValid && knownOp && (rdIdx != regIdxT'(`CPU_ZERO_REG));

endmodule

`default_nettype wire

/* design/stageReg.sv */
`timescale 1ns/10ps
`default_nettype none

module stageReg #(
    parameter type payloadT = logic         // Whatever the stage carries
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    enable,                 // Pipeline advance
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // Valid bit, cleared on reset so the stage starts empty
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (enable) begin
            outValid <= inValid;            // Bubble when nothing valid
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            outData <= inData;              // Held while stalled
        end
    end

endmodule

`default_nettype wire

/* design/cpuPkg.sv */
`default_nettype none

`include "cpu_cfg.svh"

package cpuPkg;

    // ==============================
    // Basic datapath types
    // ==============================
    typedef logic [`CPU_DATA_W-1:0]    dataT;    // Register or ALU value
    typedef logic [`CPU_REG_IDX_W-1:0] regIdxT;  // Register index
    typedef logic [`CPU_INSTR_W-1:0]   instrT;   // Raw instruction word

    typedef enum logic [1:0] {
        aluAdd,                                  // A + B
        aluSub,                                  // A - B, wraps
        aluAnd,                                  // Bitwise AND
        aluOr                                    // Bitwise OR
    } aluOpT;

    // ==============================
    // Pipeline payloads
    // ==============================
    typedef struct packed {
        dataT   opA;                             // Rn value at decode
        dataT   opB;                             // Rm value at decode
        regIdxT rnIdx;                           // Kept for forwarding compare
        regIdxT rmIdx;
        regIdxT rdIdx;                           // Destination
        dataT   imm;                             // Zero-extended imm12
        logic   useImm;                          // B from imm, not Rm
        aluOpT  aluOp;
        logic   regWrite;                        // Writes a register
    } idExT;

    typedef struct packed {
        regIdxT rdIdx;                           // Destination
        dataT   result;                          // ALU output
    } exWbT;

endpackage

`default_nettype wire

/* include/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ==============================
// Datapath sizes
// ==============================
`define CPU_DATA_W     64             // Register and ALU width
`define CPU_NUM_REGS   32             // Architectural registers
`define CPU_REG_IDX_W  5              // Bits per register index
`define CPU_INSTR_W    32             // Instruction word width
`define CPU_ZERO_REG   31             // Hardwired zero, never written

// ==============================
// Opcodes
// ==============================
`define CPU_OP_ADD     11'b10001011000  // R-type, instr[31:21]
`define CPU_OP_SUB     11'b11001011000
`define CPU_OP_AND     11'b10001010000
`define CPU_OP_ORR     11'b10101010000
`define CPU_OP_ADDI    10'b1001000100   // I-type, instr[31:22]
`define CPU_OP_SUBI    10'b1101000100

`endif
